/* Makefile */
TOP := tb_i2c_master

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f i2c_master.f

run: build
	./obj_dir/V$(TOP) | awk '{ print } /^Test completed successfully$$/ { ok = 1 } END { exit !ok }'

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f i2c_master.f

clean:
	rm -rf obj_dir

/* i2c_master.f */
source/i2c_pkg.sv
source/i2c_cmd_regs.sv
source/i2c_seq_fsm.sv
source/i2c_bit_engine.sv
source/i2c_master_top.sv
tb/i2c_master_assert.sv
tb/i2c_slave_model.sv
tb/tb_i2c_master.sv

/* source/i2c_bit_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_bit_engine (
    input  wire                        dri_clk,
    input  wire                        rst_n,
    input  wire                        phase_go,
    input  var i2c_pkg::phase_op_t     phase_op,
    input  wire  [i2c_pkg::data_w-1:0] phase_byte,
    input  wire                        sda_in,
    output logic                       phase_done,
    output logic [i2c_pkg::data_w-1:0] rx_byte,
    output logic                       scl,
    output logic                       sda_out,
    output logic                       sda_oe
);

    // last tick of each phase, four ticks per scl period
    localparam logic [5:0] last_start = 6'd39;   // 4 prologue + 8 bits + ack
    localparam logic [5:0] last_byte  = 6'd35;
    localparam logic [5:0] last_stop  = 6'd16;

    logic [5:0] cnt;
    logic [5:0] last_tick;
    logic       has_start;
    logic       is_read;
    logic       in_pre;                          // start/restart prologue
    logic [5:0] body;
    logic [3:0] slot;                            // 0..7 data, 8 ack
    logic [1:0] step;

    // ************************************************************
    // tick decode
    // ************************************************************

    always_comb begin
        has_start = (phase_op == i2c_pkg::ph_start_byte)
                 || (phase_op == i2c_pkg::ph_restart_byte);
        is_read   = (phase_op == i2c_pkg::ph_read_byte);

        if (phase_op == i2c_pkg::ph_stop) begin
            last_tick = last_stop;
        end else if (has_start) begin
            last_tick = last_start;
        end else begin
            last_tick = last_byte;
        end

        in_pre = has_start && (cnt < 6'd4);
        body   = has_start ? cnt - 6'd4 : cnt;
        slot   = body[5:2];
        step   = body[1:0];
    end

    assign phase_done = phase_go && (cnt == last_tick);

    // ************************************************************
    // scl / sda generation
    // ************************************************************

    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt     <= '0;
            scl     <= 1'b1;
            sda_out <= 1'b1;
            sda_oe  <= 1'b1;
        end else if (!phase_go) begin
            cnt     <= '0;                       // bus idle, both lines high
            scl     <= 1'b1;
            sda_out <= 1'b1;
            sda_oe  <= 1'b1;
        end else begin
            cnt <= phase_done ? 6'd0 : cnt + 6'd1;

            if (phase_op == i2c_pkg::ph_stop) begin
                case (cnt)
                    6'd0: begin
                        sda_oe  <= 1'b1;
                        sda_out <= 1'b0;
                    end
                    6'd1: scl <= 1'b1;
                    6'd3: sda_out <= 1'b1;       // stop, sda rises with scl high
                    default: ;
                endcase
            end else if (in_pre) begin
                case (cnt[1:0])
                    2'd0: begin
                        sda_oe  <= 1'b1;         // release to high before restart
                        sda_out <= 1'b1;
                    end
                    2'd1: scl <= 1'b1;
                    2'd2: sda_out <= 1'b0;       // start, sda falls with scl high
                    2'd3: scl <= 1'b0;
                endcase
            end else begin
                case (step)
                    2'd0: begin
                        if (slot == 4'd8) begin
                            sda_oe  <= is_read;  // nack on read, else slave acks
                            sda_out <= 1'b1;
                        end else begin
                            sda_oe  <= !is_read;
                            sda_out <= is_read | phase_byte[~slot[2:0]];   // msb first
                        end
                    end
                    2'd1: scl <= 1'b1;
                    2'd3: scl <= 1'b0;
                    default: ;
                endcase
            end
        end
    end

    // read data sampled as scl rises
    always_ff @(posedge dri_clk) begin
        if (phase_go && is_read && (step == 2'd1) && (slot < 4'd8)) begin
            rx_byte <= {rx_byte[i2c_pkg::data_w-2:0], sda_in};
        end
    end

endmodule

`default_nettype wire

/* source/i2c_cmd_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_cmd_regs (
    input  wire                        dri_clk,
    input  wire                        rst_n,
    input  wire                        cmd_accept,
    input  wire                        bit_ctrl,
    input  wire                        i2c_rh_wl,
    input  wire  [i2c_pkg::addr_w-1:0] i2c_addr,
    input  wire  [i2c_pkg::data_w-1:0] i2c_data_w,
    input  wire                        rd_load,
    input  wire  [i2c_pkg::data_w-1:0] rx_byte,
    output logic                       cmd_addr16,
    output logic                       cmd_read,
    output logic [i2c_pkg::addr_w-1:0] cmd_addr,
    output logic [i2c_pkg::data_w-1:0] cmd_wdata,
    output logic [i2c_pkg::data_w-1:0] i2c_data_r
);

    // ************************************************************
    // command latch
    // ************************************************************

    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_addr16 <= 1'b0;
            cmd_read   <= 1'b0;
        end else if (cmd_accept) begin
            cmd_addr16 <= bit_ctrl;              // 1: two address bytes
            cmd_read   <= i2c_rh_wl;
        end
    end

    always_ff @(posedge dri_clk) begin
        if (cmd_accept) begin
            cmd_addr  <= i2c_addr;
            cmd_wdata <= i2c_data_w;
        end
    end

    // ************************************************************
    // read result, held until the next read
    // ************************************************************

    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            i2c_data_r <= '0;
        end else if (rd_load) begin
            i2c_data_r <= rx_byte;
        end
    end

endmodule

`default_nettype wire

/* source/i2c_master_top.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_master_top #(
    parameter logic [6:0] slave_addr = 7'h3c
) (
    input  wire                        dri_clk,         // 4x scl rate
    input  wire                        rst_n,
    input  wire                        i2c_exec,
    input  wire                        bit_ctrl,
    input  wire                        i2c_rh_wl,
    input  wire  [i2c_pkg::addr_w-1:0] i2c_addr,
    input  wire  [i2c_pkg::data_w-1:0] i2c_data_w,
    input  wire                        sda_in,
    output logic [i2c_pkg::data_w-1:0] i2c_data_r,
    output logic                       i2c_done,
    output logic                       scl,
    output logic                       sda_out,
    output logic                       sda_oe
);

    logic                       cmd_accept;
    logic                       cmd_addr16;
    logic                       cmd_read;
    logic [i2c_pkg::addr_w-1:0] cmd_addr;
    logic [i2c_pkg::data_w-1:0] cmd_wdata;
    logic                       rd_load;
    logic                       phase_go;
    i2c_pkg::phase_op_t         phase_op;
    logic [i2c_pkg::data_w-1:0] phase_byte;
    logic                       phase_done;
    logic [i2c_pkg::data_w-1:0] rx_byte;

    i2c_cmd_regs u_cmd_regs (
        .dri_clk    (dri_clk),
        .rst_n      (rst_n),
        .cmd_accept (cmd_accept),
        .bit_ctrl   (bit_ctrl),
        .i2c_rh_wl  (i2c_rh_wl),
        .i2c_addr   (i2c_addr),
        .i2c_data_w (i2c_data_w),
        .rd_load    (rd_load),
        .rx_byte    (rx_byte),
        .cmd_addr16 (cmd_addr16),
        .cmd_read   (cmd_read),
        .cmd_addr   (cmd_addr),
        .cmd_wdata  (cmd_wdata),
        .i2c_data_r (i2c_data_r)
    );

    i2c_seq_fsm #(
        .slave_addr (slave_addr)
    ) u_seq_fsm (
        .dri_clk    (dri_clk),
        .rst_n      (rst_n),
        .i2c_exec   (i2c_exec),
        .cmd_addr16 (cmd_addr16),
        .cmd_read   (cmd_read),
        .cmd_addr   (cmd_addr),
        .cmd_wdata  (cmd_wdata),
        .phase_done (phase_done),
        .cmd_accept (cmd_accept),
        .phase_go   (phase_go),
        .phase_op   (phase_op),
        .phase_byte (phase_byte),
        .rd_load    (rd_load),
        .i2c_done   (i2c_done)
    );

    i2c_bit_engine u_bit_engine (
        .dri_clk    (dri_clk),
        .rst_n      (rst_n),
        .phase_go   (phase_go),
        .phase_op   (phase_op),
        .phase_byte (phase_byte),
        .sda_in     (sda_in),
        .phase_done (phase_done),
        .rx_byte    (rx_byte),
        .scl        (scl),
        .sda_out    (sda_out),
        .sda_oe     (sda_oe)                     // pad buffer lives in the board top
    );

endmodule

`default_nettype wire

/* source/i2c_pkg.sv */
`default_nettype none

package i2c_pkg;

    localparam int addr_w = 16;                  // word address
    localparam int data_w = 8;

    // sequencer states, one-hot
    typedef enum logic [7:0] {
        st_idle    = 8'b0000_0001,
        st_sladdr  = 8'b0000_0010,               // slave address + W
        st_addr16  = 8'b0000_0100,               // word address high byte
        st_addr8   = 8'b0000_1000,               // word address low byte
        st_data_wr = 8'b0001_0000,
        st_addr_rd = 8'b0010_0000,               // restart, slave address + R
        st_data_rd = 8'b0100_0000,
        st_stop    = 8'b1000_0000
    } seq_state_t;

    // what the bit engine does in the current phase
    typedef enum logic [2:0] {
        ph_start_byte   = 3'd0,
        ph_byte         = 3'd1,
        ph_restart_byte = 3'd2,
        ph_read_byte    = 3'd3,                  // byte in, then nack
        ph_stop         = 3'd4
    } phase_op_t;

endpackage

`default_nettype wire

/* source/i2c_seq_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_seq_fsm #(
    parameter logic [6:0] slave_addr = 7'h3c
) (
    input  wire                        dri_clk,
    input  wire                        rst_n,
    input  wire                        i2c_exec,
    input  wire                        cmd_addr16,
    input  wire                        cmd_read,
    input  wire  [i2c_pkg::addr_w-1:0] cmd_addr,
    input  wire  [i2c_pkg::data_w-1:0] cmd_wdata,
    input  wire                        phase_done,
    output logic                       cmd_accept,
    output logic                       phase_go,
    output i2c_pkg::phase_op_t         phase_op,
    output logic [i2c_pkg::data_w-1:0] phase_byte,
    output logic                       rd_load,
    output logic                       i2c_done
);

    i2c_pkg::seq_state_t state;
    i2c_pkg::seq_state_t state_nxt;

    assign cmd_accept = (state == i2c_pkg::st_idle) && i2c_exec;   // busy ignores exec
    assign phase_go   = (state != i2c_pkg::st_idle);
    assign rd_load    = (state == i2c_pkg::st_data_rd) && phase_done;

    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= i2c_pkg::st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // ************************************************************
    // phase sequencing
    // ************************************************************

    always_comb begin
        state_nxt = state;
        case (state)
            i2c_pkg::st_idle: begin
                if (i2c_exec) state_nxt = i2c_pkg::st_sladdr;
            end
            i2c_pkg::st_sladdr: begin
                if (phase_done) state_nxt = cmd_addr16 ? i2c_pkg::st_addr16 : i2c_pkg::st_addr8;
            end
            i2c_pkg::st_addr16: begin
                if (phase_done) state_nxt = i2c_pkg::st_addr8;
            end
            i2c_pkg::st_addr8: begin
                if (phase_done) state_nxt = cmd_read ? i2c_pkg::st_addr_rd : i2c_pkg::st_data_wr;
            end
            i2c_pkg::st_data_wr: begin
                if (phase_done) state_nxt = i2c_pkg::st_stop;
            end
            i2c_pkg::st_addr_rd: begin
                if (phase_done) state_nxt = i2c_pkg::st_data_rd;
            end
            i2c_pkg::st_data_rd: begin
                if (phase_done) state_nxt = i2c_pkg::st_stop;
            end
            i2c_pkg::st_stop: begin
                if (phase_done) state_nxt = i2c_pkg::st_idle;
            end
            default: state_nxt = i2c_pkg::st_idle;
        endcase
    end

    // opcode and byte for the bit engine
    always_comb begin
        phase_op   = i2c_pkg::ph_stop;
        phase_byte = '0;
        case (state)
            i2c_pkg::st_sladdr: begin
                phase_op   = i2c_pkg::ph_start_byte;
                phase_byte = {slave_addr, 1'b0};    // write
            end
            i2c_pkg::st_addr16: begin
                phase_op   = i2c_pkg::ph_byte;
                phase_byte = cmd_addr[15:8];
            end
            i2c_pkg::st_addr8: begin
                phase_op   = i2c_pkg::ph_byte;
                phase_byte = cmd_addr[7:0];
            end
            i2c_pkg::st_data_wr: begin
                phase_op   = i2c_pkg::ph_byte;
                phase_byte = cmd_wdata;
            end
            i2c_pkg::st_addr_rd: begin
                phase_op   = i2c_pkg::ph_restart_byte;
                phase_byte = {slave_addr, 1'b1};    // read
            end
            i2c_pkg::st_data_rd: phase_op = i2c_pkg::ph_read_byte;
            default: ;
        endcase
    end

    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            i2c_done <= 1'b0;
        end else begin
            i2c_done <= (state == i2c_pkg::st_stop) && phase_done;
        end
    end

endmodule

`default_nettype wire

/* tb/i2c_master_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_master_assert (
    input wire                dri_clk,
    input wire                rst_n,
    input wire                scl,
    input wire                sda_out,
    input wire                sda_oe,
    input wire                phase_done,
    input wire                i2c_done,
    input var i2c_pkg::phase_op_t phase_op
);

    // master sda moves with scl high only for start and stop
    assert property (@(posedge dri_clk) disable iff (!rst_n)
        (scl && $past(scl) && sda_oe && $past(sda_oe) && (sda_out != $past(sda_out)))
        |-> ((!sda_out && ($past(phase_op) == i2c_pkg::ph_start_byte
                        || $past(phase_op) == i2c_pkg::ph_restart_byte))
          || (sda_out && $past(phase_op) == i2c_pkg::ph_stop)))
        else $error("sda changed while scl high outside start or stop");

    assert property (@(posedge dri_clk) disable iff (!rst_n) phase_done |=> !phase_done)
        else $error("phase_done longer than one cycle");

    assert property (@(posedge dri_clk) disable iff (!rst_n) i2c_done |=> !i2c_done)
        else $error("i2c_done high two cycles in a row");

endmodule

bind i2c_master_top i2c_master_assert u_master_assert (
    .dri_clk    (dri_clk),
    .rst_n      (rst_n),
    .scl        (scl),
    .sda_out    (sda_out),
    .sda_oe     (sda_oe),
    .phase_done (phase_done),
    .i2c_done   (i2c_done),
    .phase_op   (phase_op)
);

`default_nettype wire

/* tb/i2c_slave_model.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_slave_model #(
    parameter logic [6:0] dev_addr = 7'h3c
) (
    input  wire  scl,
    input  wire  sda,
    input  wire  addr16,                         // word address is two bytes
    output logic sda_pull,
    output int   addr_errs
);

    logic [7:0]  mem [0:65535];
    logic [7:0]  shreg;
    logic [7:0]  txbyte;
    logic [15:0] ptr;
    logic [3:0]  bit_cnt;                        // 8 is the ack slot
    int          byte_idx;
    logic        selected;
    logic        reading;
    logic        in_txn;
    logic        restart;
    logic        skip_fall;
    logic        nack_seen;

    initial begin
        for (int i = 0; i < 65536; i++) mem[i] = 8'hff;
        sda_pull  = 1'b0;
        addr_errs = 0;
        selected  = 1'b0;
        reading   = 1'b0;
        in_txn    = 1'b0;
        restart   = 1'b0;
        ptr       = '0;
    end

    // start or repeated start
    always @(negedge sda) begin
        if (scl === 1'b1) begin
            restart   = in_txn;
            in_txn    = 1'b1;
            selected  = 1'b1;
            reading   = 1'b0;
            bit_cnt   = 4'd0;
            byte_idx  = 0;
            skip_fall = 1'b1;                    // scl falls once before bit 7
            nack_seen = 1'b0;
        end
    end

    always @(posedge sda) begin
        if (scl === 1'b1) begin                  // stop
            selected = 1'b0;
            in_txn   = 1'b0;
            sda_pull = 1'b0;
        end
    end

    always @(posedge scl) begin
        if (selected) begin
            if (bit_cnt < 4'd8) shreg = {shreg[6:0], sda};
            else if (reading) nack_seen = sda;
        end
    end

    // ************************************************************
    // byte handling on the falling clock
    // ************************************************************
    always @(negedge scl) begin
        if (selected) begin
            if (skip_fall) begin
                skip_fall = 1'b0;
            end else if (bit_cnt == 4'd7) begin
                bit_cnt = 4'd8;
                if (reading) begin
                    sda_pull = 1'b0;             // master answers
                end else if (byte_idx == 0) begin
                    if (shreg != {dev_addr, restart}) begin
                        addr_errs++;
                        $display("ERR %0t shreg address byte got %h expected %h",
                                 $time, shreg, {dev_addr, restart});
                        selected = 1'b0;
                    end else begin
                        reading  = shreg[0];
                        sda_pull = 1'b1;
                    end
                    byte_idx = 1;
                end else if (addr16 && byte_idx == 1) begin
                    ptr[15:8] = shreg;
                    sda_pull  = 1'b1;
                    byte_idx++;
                end else if (byte_idx == (addr16 ? 2 : 1)) begin
                    ptr      = addr16 ? {ptr[15:8], shreg} : {8'h00, shreg};
                    sda_pull = 1'b1;
                    byte_idx++;
                end else begin
                    mem[ptr] = shreg;
                    ptr      = ptr + 16'd1;
                    sda_pull = 1'b1;
                    byte_idx++;
                end
            end else if (bit_cnt == 4'd8) begin
                bit_cnt  = 4'd0;
                sda_pull = 1'b0;
                if (reading && !nack_seen) begin
                    txbyte   = mem[ptr];
                    ptr      = ptr + 16'd1;
                    sda_pull = !txbyte[7];
                end
            end else begin
                bit_cnt = bit_cnt + 4'd1;
                if (reading) sda_pull = !txbyte[3'd7 - bit_cnt[2:0]];
            end
        end
    end

endmodule

`default_nettype wire

/* tb/tb_i2c_master.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_i2c_master;

    localparam int wait_limit = 400;             // cycles per transaction

    logic        dri_clk;
    logic        rst_n;
    logic        i2c_exec;
    logic        bit_ctrl;
    logic        i2c_rh_wl;
    logic [15:0] i2c_addr;
    logic [7:0]  i2c_data_w;
    logic [7:0]  i2c_data_r;
    logic        i2c_done;
    logic        scl;
    logic        sda_out;
    logic        sda_oe;
    wire         sda_in;
    logic        slave_pull;
    logic        slave_a16;
    int          slave_errs;

    logic [7:0]  ref_mem [int];
    logic [7:0]  exp_rdata;
    int          errors = 0;
    int          done_cnt = 0;
    int          seed;
    int          r;
    int          start_cnt;

    assign sda_in = !(slave_pull || (sda_oe && !sda_out));   // open drain with pull-up

    initial dri_clk = 1'b0;
    always #50 dri_clk = ~dri_clk;

    i2c_master_top #(
        .slave_addr (7'h3c)
    ) UUT (
        .dri_clk    (dri_clk),
        .rst_n      (rst_n),
        .i2c_exec   (i2c_exec),
        .bit_ctrl   (bit_ctrl),
        .i2c_rh_wl  (i2c_rh_wl),
        .i2c_addr   (i2c_addr),
        .i2c_data_w (i2c_data_w),
        .sda_in     (sda_in),
        .i2c_data_r (i2c_data_r),
        .i2c_done   (i2c_done),
        .scl        (scl),
        .sda_out    (sda_out),
        .sda_oe     (sda_oe)
    );

    i2c_slave_model #(
        .dev_addr  (7'h3c)
    ) u_slave (
        .scl       (scl),
        .sda       (sda_in),
        .addr16    (slave_a16),
        .sda_pull  (slave_pull),
        .addr_errs (slave_errs)
    );

    // 8-bit commands use only the low address byte
    function automatic logic [7:0] ref_access(input logic rd, input logic a16,
                                              input logic [15:0] addr, input logic [7:0] data);
        int key;
        key = a16 ? int'(addr) : int'(addr[7:0]);
        if (!rd) begin
            ref_mem[key] = data;
            return data;
        end
        if (ref_mem.exists(key)) return ref_mem[key];
        return 8'hff;                            // slave fill
    endfunction

    // compare on every done pulse
    always @(posedge dri_clk) begin
        if (rst_n && i2c_done) begin
            done_cnt++;
            if (i2c_data_r !== exp_rdata) begin
                errors++;
                $display("ERR %0t i2c_data_r got %h expected %h", $time, i2c_data_r, exp_rdata);
            end
        end
    end

    task automatic check_idle_outputs;
        if (scl !== 1'b1) begin
            errors++;
            $display("ERR %0t scl got %b expected 1", $time, scl);
        end
        if (sda_out !== 1'b1) begin
            errors++;
            $display("ERR %0t sda_out got %b expected 1", $time, sda_out);
        end
        if (sda_oe !== 1'b1) begin
            errors++;
            $display("ERR %0t sda_oe got %b expected 1", $time, sda_oe);
        end
        if (i2c_done !== 1'b0) begin
            errors++;
            $display("ERR %0t i2c_done got %b expected 0", $time, i2c_done);
        end
        if (i2c_data_r !== 8'h00) begin
            errors++;
            $display("ERR %0t i2c_data_r got %h expected 00", $time, i2c_data_r);
        end
    endtask

    task automatic drive_cmd(input logic rd, input logic a16,
                             input logic [15:0] addr, input logic [7:0] data);
        i2c_exec   <= 1'b1;
        bit_ctrl   <= a16;
        i2c_rh_wl  <= rd;
        i2c_addr   <= addr;
        i2c_data_w <= data;
        @(posedge dri_clk);
        i2c_exec   <= 1'b0;
    endtask

    task automatic wait_done(input int base);
        int k;
        k = 0;
        while (done_cnt == base && k < wait_limit) begin
            @(posedge dri_clk);
            k++;
        end
        if (done_cnt == base) begin
            errors++;
            $display("timeout, no i2c_done within %0d cycles", wait_limit);
        end
    endtask

    task automatic run_cmd(input logic rd, input logic a16,
                           input logic [15:0] addr, input logic [7:0] data);
        int base;
        logic [7:0] val;
        base = done_cnt;
        val  = ref_access(rd, a16, addr, data);
        if (rd) exp_rdata = val;
        slave_a16 <= a16;
        drive_cmd(rd, a16, addr, data);
        wait_done(base);
        repeat (3) @(posedge dri_clk);
    endtask

    initial begin
        seed       = 32'h00cb_4cea;
        rst_n      = 1'b0;
        i2c_exec   = 1'b0;
        bit_ctrl   = 1'b0;
        i2c_rh_wl  = 1'b0;
        i2c_addr   = '0;
        i2c_data_w = '0;
        slave_a16  = 1'b0;
        exp_rdata  = 8'h00;

        repeat (2) @(posedge dri_clk);
        check_idle_outputs();                    // still in reset
        rst_n <= 1'b1;
        @(posedge dri_clk);
        check_idle_outputs();

        // ************************************************************
        // directed
        // ************************************************************
        run_cmd(1'b0, 1'b0, 16'h0012, 8'h3a);
        run_cmd(1'b1, 1'b0, 16'h0012, 8'h00);
        run_cmd(1'b0, 1'b1, 16'h1234, 8'hc1);
        run_cmd(1'b0, 1'b1, 16'h5634, 8'h7e);    // same low byte
        run_cmd(1'b1, 1'b1, 16'h1234, 8'h00);
        run_cmd(1'b1, 1'b1, 16'h5634, 8'h00);
        run_cmd(1'b1, 1'b1, 16'h0777, 8'h00);    // never written
        run_cmd(1'b0, 1'b1, 16'h0778, 8'h42);

        // only the first of two overlapping commands counts
        start_cnt = done_cnt;
        void'(ref_access(1'b0, 1'b1, 16'h0420, 8'h5a));
        slave_a16 <= 1'b1;
        drive_cmd(1'b0, 1'b1, 16'h0420, 8'h5a);
        repeat (20) @(posedge dri_clk);
        drive_cmd(1'b0, 1'b1, 16'h0421, 8'ha5);
        wait_done(start_cnt);
        repeat (300) @(posedge dri_clk);
        if (done_cnt != start_cnt + 1) begin
            errors++;
            $display("busy exec produced %0d done pulses instead of one", done_cnt - start_cnt);
        end
        run_cmd(1'b1, 1'b1, 16'h0421, 8'h00);
        run_cmd(1'b1, 1'b1, 16'h0420, 8'h00);

        // ************************************************************
        // random
        // ************************************************************
        for (int i = 0; i < 40; i++) begin
            r = $random(seed);
            run_cmd(r[0], r[1], {7'h00, r[2], 5'h00, r[5:3]}, r[15:8]);
        end

        $display("errors: %0d, slave address errors: %0d", errors, slave_errs);
        if (errors + slave_errs == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
